/* gat_lite_pkg.sv */
package gat_lite_pkg;

  // feature memory addressing, 4096 words
  localparam int ADDR_W = 12;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [31:0]       data_t;
  typedef logic signed [15:0] weight_t;

  // node header as stored in feature memory
  // nbr_base carries an address in its low ADDR_W bits, the rest is padding
  typedef struct packed {
    logic [15:0] nbr_base;
    logic [15:0] nbr_cnt;
  } node_hdr_t;

  // the aggregator reads one memory word either as a header or as a feature
  typedef union packed {
    data_t     raw;
    node_hdr_t hdr;
  } node_word_u;

  // sticky debug flags, host_wr_seen is bit 4 and aggr_done_seen is bit 0
  typedef struct packed {
    logic host_wr_seen;
    logic dmvm_wr_seen;
    logic dmvm_done_seen;
    logic aggr_rd_seen;
    logic aggr_done_seen;
  } dbg_flags_t;

endpackage

/* mem_port_if.sv */
interface mem_port_if import gat_lite_pkg::*; ();

  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;
  logic  gnt;
  data_t rdata;

  // a requester holds req, we, addr and wdata until gnt is seen
  // read data comes back on rdata in the cycle after the grant
  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

/* feat_bram.sv */
module feat_bram import gat_lite_pkg::*; #(
  parameter int MEM_DEPTH = 4096
) (
  input  logic  clk,
  input  logic  en_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  output data_t rdata_o
);

  data_t mem [MEM_DEPTH];

  // single port, read data registered, the output holds during writes
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* feat_mem_arbiter.sv */
module feat_mem_arbiter import gat_lite_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  mem_port_if.arbiter  host_p,
  mem_port_if.arbiter  dmvm_p,
  mem_port_if.arbiter  aggr_p,
  output logic         mem_en_o,
  output logic         mem_we_o,
  output addr_t        mem_addr_o,
  output data_t        mem_wdata_o,
  input  data_t        mem_rdata_i,
  output logic         wr_stb_o,
  output addr_t        wr_addr_o,
  output data_t        wr_data_o
);

  logic       host_gnt;
  logic       dmvm_gnt;
  logic       aggr_gnt;
  // owner of the read in flight, bit 2 host, bit 1 dmvm, bit 0 aggr
  logic [2:0] rd_own_q;

  // fixed priority, the host is never held off
  assign host_gnt = host_p.req;
  assign dmvm_gnt = dmvm_p.req && !host_p.req;
  assign aggr_gnt = aggr_p.req && !host_p.req && !dmvm_p.req;

  assign host_p.gnt = host_gnt;
  assign dmvm_p.gnt = dmvm_gnt;
  assign aggr_p.gnt = aggr_gnt;

  assign mem_en_o = host_gnt || dmvm_gnt || aggr_gnt;

  always_comb begin
    mem_we_o    = 1'b0;
    mem_addr_o  = '0;
    mem_wdata_o = '0;
    if (host_gnt) begin
      mem_we_o    = host_p.we;
      mem_addr_o  = host_p.addr;
      mem_wdata_o = host_p.wdata;
    end else if (dmvm_gnt) begin
      mem_we_o    = dmvm_p.we;
      mem_addr_o  = dmvm_p.addr;
      mem_wdata_o = dmvm_p.wdata;
    end else if (aggr_gnt) begin
      mem_we_o    = aggr_p.we;
      mem_addr_o  = aggr_p.addr;
      mem_wdata_o = aggr_p.wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_own_q <= '0;
    end else begin
      rd_own_q <= {host_gnt && !host_p.we, dmvm_gnt && !dmvm_p.we, aggr_gnt && !aggr_p.we};
    end
  end

  // only the peer that won the read sees the returning word
  assign host_p.rdata = rd_own_q[2] ? mem_rdata_i : '0;
  assign dmvm_p.rdata = rd_own_q[1] ? mem_rdata_i : '0;
  assign aggr_p.rdata = rd_own_q[0] ? mem_rdata_i : '0;

  assign wr_stb_o  = mem_en_o && mem_we_o;
  assign wr_addr_o = mem_addr_o;
  assign wr_data_o = mem_wdata_o;

endmodule

/* dmvm_unit.sv */
module dmvm_unit import gat_lite_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start_i,
  input  addr_t          src_base_i,
  input  addr_t          dst_base_i,
  input  logic [15:0]    len_i,
  input  weight_t        weight_i,
  mem_port_if.requester  mem,
  output logic           busy_o,
  output logic           wr_stb_o,
  output logic           done_o
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RD   = 2'd1;
  localparam logic [1:0] S_WR   = 2'd2;
  localparam logic [1:0] S_DONE = 2'd3;

  logic [1:0]         state_q;
  logic [15:0]        idx_q;
  logic               rd_vld_q;
  addr_t              src_q;
  addr_t              dst_q;
  logic [15:0]        len_q;
  weight_t            weight_q;
  data_t              word_q;
  data_t              src_word;
  logic signed [47:0] prod;
  logic               last_elem;

  assign busy_o    = (state_q != S_IDLE);
  assign done_o    = (state_q == S_DONE);
  assign wr_stb_o  = (state_q == S_WR) && mem.gnt;
  assign last_elem = (idx_q + 16'd1 == len_q);

  // rdata carries the source word only in the first write cycle, later it comes from word_q
  assign src_word = rd_vld_q ? mem.rdata : word_q;
  assign prod     = $signed(src_word) * weight_q;

  // ##########################################################
  // memory port
  assign mem.req   = (state_q == S_RD) || (state_q == S_WR);
  assign mem.we    = (state_q == S_WR);
  assign mem.addr  = (state_q == S_WR) ? dst_q + idx_q[ADDR_W-1:0]
                                       : src_q + idx_q[ADDR_W-1:0];
  assign mem.wdata = prod[31:0];

  // ##########################################################
  // element sequencing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= S_IDLE;
      idx_q    <= '0;
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= (state_q == S_RD) && mem.gnt;
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            idx_q   <= '0;
            state_q <= (len_i == 16'd0) ? S_DONE : S_RD;
          end
        end
        S_RD: begin
          if (mem.gnt) begin
            state_q <= S_WR;
          end
        end
        S_WR: begin
          if (mem.gnt) begin
            if (last_elem) begin
              state_q <= S_DONE;
            end else begin
              idx_q   <= idx_q + 16'd1;
              state_q <= S_RD;
            end
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == S_IDLE) && start_i) begin
      src_q    <= src_base_i;
      dst_q    <= dst_base_i;
      len_q    <= len_i;
      weight_q <= weight_i;
    end
    if (rd_vld_q) begin
      word_q <= mem.rdata;
    end
  end

endmodule

/* aggr_unit.sv */
module aggr_unit import gat_lite_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start_i,
  input  addr_t          node_addr_i,
  mem_port_if.requester  mem,
  output logic           rd_stb_o,
  output data_t          sum_o,
  output logic           sum_vld_o
);

  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_HDR  = 3'd1;
  localparam logic [2:0] S_HDAT = 3'd2;
  localparam logic [2:0] S_FEAT = 3'd3;
  localparam logic [2:0] S_DONE = 3'd4;

  logic [2:0]  state_q;
  logic [15:0] issued_q;
  logic        rd_vld_q;
  addr_t       node_q;
  addr_t       base_q;
  logic [15:0] cnt_q;
  data_t       acc_q;
  node_word_u  rd_word;
  addr_t       hdr_base;
  logic [15:0] hdr_cnt;
  logic        feat_last;

  // the same returning word is a header in S_HDAT and a feature in S_FEAT
  assign rd_word.raw = mem.rdata;
  assign hdr_base    = rd_word.hdr.nbr_base[ADDR_W-1:0];
  assign hdr_cnt     = rd_word.hdr.nbr_cnt;

  assign rd_stb_o = ((state_q == S_HDAT) || (state_q == S_FEAT)) && mem.gnt;

  // one read in flight at most, so data with every read granted is the last word
  assign feat_last = rd_vld_q && (issued_q == cnt_q);

  // ##########################################################
  // memory port
  // the header read goes out with start, the first feature read with the header
  always_comb begin
    mem.req  = 1'b0;
    mem.addr = node_q;
    case (state_q)
      S_IDLE: begin
        mem.req  = start_i;
        mem.addr = node_addr_i;
      end
      S_HDR: begin
        mem.req = 1'b1;
      end
      S_HDAT: begin
        mem.req  = (hdr_cnt != 16'd0);
        mem.addr = hdr_base;
      end
      S_FEAT: begin
        mem.req  = (issued_q != cnt_q);
        mem.addr = base_q + issued_q[ADDR_W-1:0];
      end
      default: begin
        mem.req = 1'b0;
      end
    endcase
  end

  assign mem.we    = 1'b0;
  assign mem.wdata = '0;

  // ##########################################################
  // sequencing and accumulation
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= S_IDLE;
      issued_q <= '0;
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_stb_o;
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            state_q <= mem.gnt ? S_HDAT : S_HDR;
          end
        end
        S_HDR: begin
          if (mem.gnt) begin
            state_q <= S_HDAT;
          end
        end
        S_HDAT: begin
          issued_q <= rd_stb_o ? 16'd1 : 16'd0;
          state_q  <= (hdr_cnt == 16'd0) ? S_DONE : S_FEAT;
        end
        S_FEAT: begin
          if (rd_stb_o) begin
            issued_q <= issued_q + 16'd1;
          end
          if (feat_last) begin
            state_q <= S_DONE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == S_IDLE) && start_i) begin
      node_q <= node_addr_i;
      acc_q  <= '0;
    end
    if (state_q == S_HDAT) begin
      base_q <= hdr_base;
      cnt_q  <= hdr_cnt;
    end
    if ((state_q == S_FEAT) && rd_vld_q) begin
      acc_q <= acc_q + rd_word.raw;
    end
  end

  assign sum_o     = acc_q;
  assign sum_vld_o = (state_q == S_DONE);

endmodule

/* debug_monitor.sv */
module debug_monitor import gat_lite_pkg::*; #(
  parameter addr_t WATCH_ADDR_A = 12'd10,
  parameter addr_t WATCH_ADDR_B = 12'd20
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        dbg_clr_i,
  input  logic        host_wr_i,
  input  logic        dmvm_wr_i,
  input  logic        dmvm_done_i,
  input  logic        aggr_rd_i,
  input  logic        aggr_done_i,
  input  logic        wr_stb_i,
  input  addr_t       wr_addr_i,
  input  data_t       wr_data_i,
  output dbg_flags_t  flags_o,
  output logic [31:0] count_o,
  output data_t       snap_a_o,
  output data_t       snap_b_o
);

  dbg_flags_t  flags_q;
  logic [31:0] count_q;
  data_t       snap_a_q;
  data_t       snap_b_q;

  // ##########################################################
  // sticky flags and aggregation counter, clear wins over a strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
      count_q <= '0;
    end else if (dbg_clr_i) begin
      flags_q <= '0;
      count_q <= '0;
    end else begin
      if (host_wr_i) begin
        flags_q.host_wr_seen <= 1'b1;
      end
      if (dmvm_wr_i) begin
        flags_q.dmvm_wr_seen <= 1'b1;
      end
      if (dmvm_done_i) begin
        flags_q.dmvm_done_seen <= 1'b1;
      end
      if (aggr_rd_i) begin
        flags_q.aggr_rd_seen <= 1'b1;
      end
      if (aggr_done_i) begin
        flags_q.aggr_done_seen <= 1'b1;
        count_q                <= count_q + 32'd1;
      end
    end
  end

  // ##########################################################
  // watch address snapshots, kept across a debug clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      snap_a_q <= '0;
      snap_b_q <= '0;
    end else begin
      if (wr_stb_i && (wr_addr_i == WATCH_ADDR_A)) begin
        snap_a_q <= wr_data_i;
      end
      if (wr_stb_i && (wr_addr_i == WATCH_ADDR_B)) begin
        snap_b_q <= wr_data_i;
      end
    end
  end

  assign flags_o  = flags_q;
  assign count_o  = count_q;
  assign snap_a_o = snap_a_q;
  assign snap_b_o = snap_b_q;

endmodule

/* gat_lite_top.sv */
module gat_lite_top import gat_lite_pkg::*; #(
  parameter int    MEM_DEPTH    = 4096,
  parameter addr_t WATCH_ADDR_A = 12'd10,
  parameter addr_t WATCH_ADDR_B = 12'd20
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        host_we_i,
  input  logic        host_re_i,
  input  addr_t       host_addr_i,
  input  data_t       host_wdata_i,
  output data_t       host_rdata_o,
  input  logic        dmvm_start_i,
  input  addr_t       dmvm_src_i,
  input  addr_t       dmvm_dst_i,
  input  logic [15:0] dmvm_len_i,
  input  weight_t     dmvm_weight_i,
  output logic        dmvm_done_o,
  input  logic        aggr_start_i,
  input  addr_t       aggr_node_i,
  output data_t       aggr_sum_o,
  output logic        aggr_sum_vld_o,
  input  logic        dbg_clr_i,
  output dbg_flags_t  dbg_flags_o,
  output logic [31:0] dbg_count_o,
  output data_t       dbg_snap_a_o,
  output data_t       dbg_snap_b_o
);

  mem_port_if host_if ();
  mem_port_if dmvm_if ();
  mem_port_if aggr_if ();

  logic  mem_en;
  logic  mem_we;
  addr_t mem_addr;
  data_t mem_wdata;
  data_t mem_rdata;
  logic  wr_stb;
  addr_t wr_addr;
  data_t wr_data;
  logic  dmvm_wr_stb;
  logic  aggr_rd_stb;

  // host strobes map straight onto its port, it always wins the arbiter
  assign host_if.req   = host_we_i || host_re_i;
  assign host_if.we    = host_we_i;
  assign host_if.addr  = host_addr_i;
  assign host_if.wdata = host_wdata_i;
  assign host_rdata_o  = host_if.rdata;

  // ##########################################################
  // shared feature memory
  feat_bram #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_feat_bram (
    .clk     (clk),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  feat_mem_arbiter u_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_p      (host_if),
    .dmvm_p      (dmvm_if),
    .aggr_p      (aggr_if),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata),
    .wr_stb_o    (wr_stb),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data)
  );

  // ##########################################################
  // compute peers and debug
  dmvm_unit u_dmvm (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (dmvm_start_i),
    .src_base_i (dmvm_src_i),
    .dst_base_i (dmvm_dst_i),
    .len_i      (dmvm_len_i),
    .weight_i   (dmvm_weight_i),
    .mem        (dmvm_if),
    .busy_o     (),
    .wr_stb_o   (dmvm_wr_stb),
    .done_o     (dmvm_done_o)
  );

  aggr_unit u_aggr (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (aggr_start_i),
    .node_addr_i (aggr_node_i),
    .mem         (aggr_if),
    .rd_stb_o    (aggr_rd_stb),
    .sum_o       (aggr_sum_o),
    .sum_vld_o   (aggr_sum_vld_o)
  );

  debug_monitor #(
    .WATCH_ADDR_A (WATCH_ADDR_A),
    .WATCH_ADDR_B (WATCH_ADDR_B)
  ) u_debug (
    .clk         (clk),
    .rst_n       (rst_n),
    .dbg_clr_i   (dbg_clr_i),
    .host_wr_i   (host_we_i),
    .dmvm_wr_i   (dmvm_wr_stb),
    .dmvm_done_i (dmvm_done_o),
    .aggr_rd_i   (aggr_rd_stb),
    .aggr_done_i (aggr_sum_vld_o),
    .wr_stb_i    (wr_stb),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .flags_o     (dbg_flags_o),
    .count_o     (dbg_count_o),
    .snap_a_o    (dbg_snap_a_o),
    .snap_b_o    (dbg_snap_b_o)
  );

endmodule

/* tb_gat_lite_ref.svh */
`ifndef TB_GAT_LITE_REF_SVH
`define TB_GAT_LITE_REF_SVH

// ##########################################################
// shadow of the feature memory, follows every write the DUT should perform
data_t shadow [4096];
data_t snap_a_exp = '0;
data_t snap_b_exp = '0;

function automatic void shadow_write(input addr_t a, input data_t d);
  shadow[a] = d;
  if (a == WATCH_A) begin
    snap_a_exp = d;
  end
  if (a == WATCH_B) begin
    snap_b_exp = d;
  end
endfunction

// low 32 bits of the signed word times the signed weight
function automatic data_t ref_scale(input data_t src, input weight_t w);
  longint prod;
  prod = longint'($signed(src)) * longint'(w);
  return prod[31:0];
endfunction

// the header keeps the neighbor base in bits 27:16 and the count in bits 15:0
function automatic data_t ref_aggr(input addr_t node);
  data_t hdr;
  addr_t base;
  int    cnt;
  data_t sum;
  hdr  = shadow[node];
  base = hdr[27:16];
  cnt  = hdr[15:0];
  sum  = '0;
  for (int k = 0; k < cnt; k++) begin
    sum = sum + shadow[addr_t'(base + k)];
  end
  return sum;
endfunction

function automatic dbg_flags_t ref_flags(input bit host_wr, input bit dmvm_wr,
                                         input bit dmvm_done, input bit aggr_rd,
                                         input bit aggr_done);
  dbg_flags_t f;
  f.host_wr_seen   = host_wr;
  f.dmvm_wr_seen   = dmvm_wr;
  f.dmvm_done_seen = dmvm_done;
  f.aggr_rd_seen   = aggr_rd;
  f.aggr_done_seen = aggr_done;
  return f;
endfunction

`endif

/* tb_gat_lite.sv */
module tb_gat_lite import gat_lite_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam addr_t WATCH_A = 12'd10;
  localparam addr_t WATCH_B = 12'd20;
  localparam int    TIMEOUT = 2000;

  logic        clk;
  logic        rst_n;
  logic        host_we_i;
  logic        host_re_i;
  addr_t       host_addr_i;
  data_t       host_wdata_i;
  data_t       host_rdata_o;
  logic        dmvm_start_i;
  addr_t       dmvm_src_i;
  addr_t       dmvm_dst_i;
  logic [15:0] dmvm_len_i;
  weight_t     dmvm_weight_i;
  logic        dmvm_done_o;
  logic        aggr_start_i;
  addr_t       aggr_node_i;
  data_t       aggr_sum_o;
  logic        aggr_sum_vld_o;
  logic        dbg_clr_i;
  dbg_flags_t  dbg_flags_o;
  logic [31:0] dbg_count_o;
  data_t       dbg_snap_a_o;
  data_t       dbg_snap_b_o;

  integer seed       = 32'h04a33a03;
  int     vld_seen   = 0;
  int     done_seen  = 0;
  int     aggr_runs  = 0;
  int     dmvm_runs  = 0;
  logic   rd_pending = 1'b0;
  data_t  rd_exp_q [$];
  data_t  sum_exp_q [$];
  bit     seen_host_wr;
  bit     seen_dmvm_wr;
  bit     seen_dmvm_done;
  bit     seen_aggr_rd;
  bit     seen_aggr_done;

  `include "tb_gat_lite_ref.svh"

  gat_lite_top #(
    .MEM_DEPTH    (4096),
    .WATCH_ADDR_A (WATCH_A),
    .WATCH_ADDR_B (WATCH_B)
  ) DUT (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ##########################################################
  // checks
  task automatic raise_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      raise_error($sformatf("FAIL %s got %08h expected %08h", name, got, exp));
    end
  endtask

  task automatic check_flags(input string name, input dbg_flags_t got, input dbg_flags_t exp);
    if (got !== exp) begin
      raise_error($sformatf("FAIL %s got %02h expected %02h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      raise_error($sformatf("FAIL %s got %08h expected %08h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      raise_error($sformatf("FAIL %s got %0h expected %0h", name, got, exp));
    end
  endtask

  // a host read issued in the last cycle has its data on host_rdata_o now
  always @(posedge clk) begin
    rd_pending <= host_re_i;
  end

  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (rd_pending === 1'b1) begin
        check_data("host_rdata_o", host_rdata_o, rd_exp_q.pop_front());
      end
      if (aggr_sum_vld_o === 1'b1) begin
        if (sum_exp_q.size() == 0) begin
          raise_error("aggregation result arrived without a started aggregation");
        end else begin
          check_data("aggr_sum_o", aggr_sum_o, sum_exp_q.pop_front());
        end
        vld_seen++;
      end
      if (dmvm_done_o === 1'b1) begin
        if (done_seen >= dmvm_runs) begin
          raise_error("scaling done arrived without a started scaling run");
        end
        done_seen++;
      end
    end
  end

  // ##########################################################
  // stimulus
  function automatic data_t rand_word();
    return $random(seed);
  endfunction

  function automatic addr_t rand_addr();
    return addr_t'($unsigned($random(seed)) % 512);
  endfunction

  task automatic host_write(input addr_t a, input data_t d);
    @(posedge clk);
    host_we_i    <= 1'b1;
    host_addr_i  <= a;
    host_wdata_i <= d;
    shadow_write(a, d);
    seen_host_wr = 1'b1;
    @(posedge clk);
    host_we_i <= 1'b0;
  endtask

  task automatic host_read(input addr_t a);
    @(posedge clk);
    host_re_i   <= 1'b1;
    host_addr_i <= a;
    rd_exp_q.push_back(shadow[a]);
    @(posedge clk);
    host_re_i <= 1'b0;
  endtask

  task automatic start_dmvm(input addr_t src, input addr_t dst, input int len, input weight_t w);
    @(posedge clk);
    dmvm_start_i  <= 1'b1;
    dmvm_src_i    <= src;
    dmvm_dst_i    <= dst;
    dmvm_len_i    <= 16'(len);
    dmvm_weight_i <= w;
    for (int k = 0; k < len; k++) begin
      shadow_write(addr_t'(dst + k), ref_scale(shadow[addr_t'(src + k)], w));
    end
    dmvm_runs++;
    seen_dmvm_done = 1'b1;
    if (len != 0) begin
      seen_dmvm_wr = 1'b1;
    end
    @(posedge clk);
    dmvm_start_i <= 1'b0;
  endtask

  task automatic start_aggr(input addr_t node);
    data_t hdr;
    hdr = shadow[node];
    @(posedge clk);
    aggr_start_i <= 1'b1;
    aggr_node_i  <= node;
    sum_exp_q.push_back(ref_aggr(node));
    aggr_runs++;
    seen_aggr_done = 1'b1;
    if (hdr[15:0] != 16'd0) begin
      seen_aggr_rd = 1'b1;
    end
    @(posedge clk);
    aggr_start_i <= 1'b0;
  endtask

  task automatic wait_engines();
    int cycles;
    cycles = 0;
    while ((vld_seen < aggr_runs) || (done_seen < dmvm_runs)) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        raise_error("timeout while waiting for the engines to finish");
      end
    end
  endtask

  task automatic wait_reads_done();
    int cycles;
    cycles = 0;
    while (rd_exp_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        raise_error("timeout while waiting for host read data");
      end
    end
  endtask

  task automatic read_back_range(input addr_t first, input int count);
    for (int k = 0; k < count; k++) begin
      host_read(addr_t'(first + k));
    end
    wait_reads_done();
  endtask

  initial begin
    addr_t   a;
    addr_t   dst;
    int      len;
    weight_t w;
    data_t   r;
    rst_n         = 1'b0;
    host_we_i     = 1'b0;
    host_re_i     = 1'b0;
    host_addr_i   = '0;
    host_wdata_i  = '0;
    dmvm_start_i  = 1'b0;
    dmvm_src_i    = '0;
    dmvm_dst_i    = '0;
    dmvm_len_i    = '0;
    dmvm_weight_i = '0;
    aggr_start_i  = 1'b0;
    aggr_node_i   = '0;
    dbg_clr_i     = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flags("dbg_flags_o", dbg_flags_o, ref_flags(0, 0, 0, 0, 0));
    check_count("dbg_count_o", dbg_count_o, 32'd0);
    check_data("dbg_snap_a_o", dbg_snap_a_o, 32'd0);
    check_data("dbg_snap_b_o", dbg_snap_b_o, 32'd0);
    check_bit("dmvm_done_o", dmvm_done_o, 1'b0);
    check_bit("aggr_sum_vld_o", aggr_sum_vld_o, 1'b0);

    // the low 512 words are all defined before anything reads them
    for (int i = 0; i < 512; i++) begin
      host_write(addr_t'(i), rand_word());
    end
    for (int i = 0; i < 16; i++) begin
      a = rand_addr();
      host_write(a, rand_word());
      host_read(a);
    end
    for (int i = 0; i < 32; i++) begin
      host_read(rand_addr());
    end
    wait_reads_done();

    // ##########################################################
    // scaling runs where the first one covers watch address B
    for (int i = 0; i < 4; i++) begin
      len = (i == 0) ? 8 : ((i == 3) ? 0 : 1 + ($unsigned($random(seed)) % 16));
      dst = (i == 0) ? WATCH_B - 12'd4 : addr_t'(256 + 32 * i);
      r   = rand_word();
      w   = r[15:0];
      start_dmvm(addr_t'(128 + 32 * i), dst, len, w);
      wait_engines();
      read_back_range(dst - 12'd2, len + 4);
    end

    // ##########################################################
    // aggregation with neighbor counts 0, 1, 5 and 12
    host_write(12'd440, {4'h0, 12'd32, 16'd0});
    host_write(12'd441, {4'h0, 12'd40, 16'd1});
    host_write(12'd442, {4'h0, 12'd40, 16'd5});
    host_write(12'd443, {4'h0, 12'd48, 16'd12});
    for (int i = 0; i < 4; i++) begin
      start_aggr(addr_t'(440 + i));
      wait_engines();
    end
    r = rand_word();
    w = r[15:0];
    start_dmvm(12'd160, 12'd320, 16, w);
    start_aggr(12'd443);
    for (int i = 0; i < 6; i++) begin
      host_write(addr_t'(480 + i), rand_word());
    end
    wait_engines();
    read_back_range(12'd318, 20);
    @(negedge clk);
    check_flags("dbg_flags_o", dbg_flags_o,
                ref_flags(seen_host_wr, seen_dmvm_wr, seen_dmvm_done, seen_aggr_rd,
                          seen_aggr_done));
    check_count("dbg_count_o", dbg_count_o, aggr_runs);
    check_data("dbg_snap_a_o", dbg_snap_a_o, snap_a_exp);
    check_data("dbg_snap_b_o", dbg_snap_b_o, snap_b_exp);

    // ##########################################################
    // debug clear followed by a single aggregation
    host_write(12'd444, {4'h0, 12'd80, 16'd3});
    @(posedge clk);
    dbg_clr_i <= 1'b1;
    @(posedge clk);
    dbg_clr_i <= 1'b0;
    @(negedge clk);
    check_flags("dbg_flags_o", dbg_flags_o, ref_flags(0, 0, 0, 0, 0));
    check_count("dbg_count_o", dbg_count_o, 32'd0);
    check_data("dbg_snap_a_o", dbg_snap_a_o, snap_a_exp);
    check_data("dbg_snap_b_o", dbg_snap_b_o, snap_b_exp);
    seen_host_wr   = 1'b0;
    seen_dmvm_wr   = 1'b0;
    seen_dmvm_done = 1'b0;
    seen_aggr_rd   = 1'b0;
    seen_aggr_done = 1'b0;
    start_aggr(12'd444);
    wait_engines();
    @(negedge clk);
    check_flags("dbg_flags_o", dbg_flags_o,
                ref_flags(seen_host_wr, seen_dmvm_wr, seen_dmvm_done, seen_aggr_rd,
                          seen_aggr_done));
    check_count("dbg_count_o", dbg_count_o, 32'd1);

    $display("No errors");
    $finish;
  end

endmodule

/* gat_lite.f */
+incdir+.
gat_lite_pkg.sv
mem_port_if.sv
feat_bram.sv
feat_mem_arbiter.sv
dmvm_unit.sv
aggr_unit.sv
debug_monitor.sv
gat_lite_top.sv
tb_gat_lite.sv
